/* mem_macros.svh */
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// ----------------------------------------------------------------------
// Data memory geometry
// ----------------------------------------------------------------------

`define MEM_WORDS   1024                // 32-bit words in the RAM

// Byte address covers the word index plus the two lane bits
`define MEM_ADDR_W  12

`endif

/* mem_pkg.sv */
`default_nettype none

`include "mem_macros.svh"

package mem_pkg;

    // ----------------------------------------------------------------------
    // Access size
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2                    // 2'd3 is reserved
    } access_size_e;

    // ----------------------------------------------------------------------
    // Port command, pipeline word and response
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic                   wr;         // Store when set
        access_size_e           size;
        logic                   uns;        // Zero-extend on load
        logic [`MEM_ADDR_W-1:0] addr;       // Byte address
        logic [31:0]            wdata;      // Store data, low aligned
    } mem_cmd_t;

    typedef struct packed {
        logic                   port_id;    // 0 for port A, 1 for port B
        logic                   wr;
        logic                   ok;         // Clear on misaligned access
        access_size_e           size;
        logic                   uns;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [3:0]             strb;       // Lane strobe before shifting
        logic [31:0]            wdata;
    } ram_op_t;

    typedef struct packed {
        logic                   err;
        logic                   wr;
        logic [31:0]            data;       // Load result, zero for stores
    } mem_rsp_t;

endpackage

`default_nettype wire

/* mem_req_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_req_arbiter (
    input  wire logic               CLK,
    input  wire logic               rst_n,
    input  wire mem_pkg::mem_cmd_t  a_cmd,
    input  wire logic               a_cmd_valid,
    output logic                    a_cmd_ready,
    input  wire mem_pkg::mem_cmd_t  b_cmd,
    input  wire logic               b_cmd_valid,
    output logic                    b_cmd_ready,
    input  wire logic               slot_free,
    output mem_pkg::ram_op_t        ram_op,
    output logic                    op_valid
);

    localparam logic [1:0] CREDITS = 2'd2;  // Depth of the response buffer

    logic [1:0]         credits;
    logic               running;            // Low until the first clock
    logic               has_credit;
    logic               take_a;
    logic               take_b;
    logic               accept;
    mem_pkg::mem_cmd_t  sel_cmd;
    logic               misaligned;
    logic [3:0]         strb;

    // ----------------------------------------------------------------------
    // Handshake, port B wins
    // ----------------------------------------------------------------------
    assign has_credit  = running && (credits != 2'd0);
    assign b_cmd_ready = has_credit;
    assign a_cmd_ready = has_credit && !b_cmd_valid;

    assign take_b  = b_cmd_valid && b_cmd_ready;
    assign take_a  = a_cmd_valid && a_cmd_ready;
    assign accept  = take_a || take_b;
    assign sel_cmd = take_b ? b_cmd : a_cmd;

    // ----------------------------------------------------------------------
    // Alignment check and strobe
    // ----------------------------------------------------------------------
    always_comb begin
        strb       = 4'b0000;
        misaligned = 1'b0;
        case (sel_cmd.size)
            mem_pkg::size_byte: begin
                strb = 4'b0001;
            end
            mem_pkg::size_half: begin
                strb       = 4'b0011;
                misaligned = sel_cmd.addr[0];
            end
            mem_pkg::size_word: begin
                strb       = 4'b1111;
                misaligned = (sel_cmd.addr[1:0] != 2'b00);
            end
            default: begin
                misaligned = 1'b1;          // Reserved size code
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // Pipeline word to the RAM
    // ----------------------------------------------------------------------
    always_comb begin
        ram_op.port_id = take_b;
        ram_op.wr      = sel_cmd.wr;
        ram_op.ok      = !misaligned;
        ram_op.size    = sel_cmd.size;
        ram_op.uns     = sel_cmd.uns;
        ram_op.addr    = sel_cmd.addr;
        ram_op.strb    = strb;
        ram_op.wdata   = sel_cmd.wdata;
    end

    assign op_valid = accept;

    // ----------------------------------------------------------------------
    // Response credits
    // ----------------------------------------------------------------------
    // One credit per buffer slot, so the RAM pipeline never stalls
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            credits <= CREDITS;
        end else begin
            running <= 1'b1;
            case ({accept, slot_free})
                2'b10:   credits <= credits - 2'd1;
                2'b01:   credits <= credits + 2'd1;
                default: credits <= credits;    // Spent and returned together
            endcase
        end
    end

endmodule

`default_nettype wire

/* data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module data_ram (
    input  wire logic               CLK,
    input  wire logic               rst_n,
    input  wire mem_pkg::ram_op_t   ram_op,
    input  wire logic               op_valid,
    output mem_pkg::ram_op_t        rd_op,
    output logic                    rd_valid,
    output logic [31:0]             rd_word
);

    localparam int IDX_W = `MEM_ADDR_W - 2;

    logic [31:0]        mem [0:`MEM_WORDS-1];

    // Stage 1, operation and raw read word
    mem_pkg::ram_op_t   s1_op;
    logic               s1_valid;
    logic [31:0]        s1_word;
    logic [IDX_W-1:0]   s1_idx;

    // Write-back copies, wb1 is the newer one
    logic               wb1_valid;
    logic [IDX_W-1:0]   wb1_idx;
    logic [31:0]        wb1_data;
    logic               wb2_valid;
    logic [IDX_W-1:0]   wb2_idx;
    logic [31:0]        wb2_data;

    logic [31:0]        cur_word;
    logic [31:0]        merged;
    logic               wr_en;

    // ----------------------------------------------------------------------
    // Lane merge
    // ----------------------------------------------------------------------
    // Store data is replicated across the lanes and the shifted strobe
    // picks which of them replace the old word
    function automatic logic [31:0] merge_word(
        input logic [31:0]      old_word,
        input mem_pkg::ram_op_t op
    );
        logic [3:0]  lanes;
        logic [31:0] rep;
        logic [31:0] res;
        lanes = op.strb << op.addr[1:0];
        case (op.size)
            mem_pkg::size_byte: rep = {4{op.wdata[7:0]}};
            mem_pkg::size_half: rep = {2{op.wdata[15:0]}};
            default:            rep = op.wdata;
        endcase
        for (int i = 0; i < 4; i++) begin
            res[8*i +: 8] = lanes[i] ? rep[8*i +: 8] : old_word[8*i +: 8];
        end
        return res;
    endfunction

    assign s1_idx = s1_op.addr[`MEM_ADDR_W-1:2];

    // ----------------------------------------------------------------------
    // Write forwarding
    // ----------------------------------------------------------------------
    always_comb begin
        if (wb1_valid && (wb1_idx == s1_idx)) begin
            cur_word = wb1_data;            // Written on the same edge as our read
        end else if (wb2_valid && (wb2_idx == s1_idx)) begin
            cur_word = wb2_data;
        end else begin
            cur_word = s1_word;
        end
    end

    assign merged = merge_word(cur_word, s1_op);
    assign wr_en  = s1_valid && s1_op.wr && s1_op.ok;

    // ----------------------------------------------------------------------
    // Block RAM, read-first
    // ----------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (op_valid) begin
            s1_word <= mem[ram_op.addr[`MEM_ADDR_W-1:2]];
        end
        if (wr_en) begin
            mem[s1_idx] <= merged;
        end
    end

    // Payload stages
    always_ff @(posedge CLK) begin
        s1_op    <= ram_op;
        wb1_idx  <= s1_idx;
        wb1_data <= merged;
        wb2_idx  <= wb1_idx;
        wb2_data <= wb1_data;
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            wb1_valid <= 1'b0;
            wb2_valid <= 1'b0;
        end else begin
            s1_valid  <= op_valid;
            wb1_valid <= wr_en;             // Only real writes are forwarded
            wb2_valid <= wb1_valid;
        end
    end

    // ----------------------------------------------------------------------
    // Outputs to load alignment
    // ----------------------------------------------------------------------
    assign rd_op    = s1_op;
    assign rd_valid = s1_valid;
    assign rd_word  = cur_word;

endmodule

`default_nettype wire

/* load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  wire logic               CLK,
    input  wire logic               rst_n,
    input  wire mem_pkg::ram_op_t   rd_op,
    input  wire logic               rd_valid,
    input  wire logic [31:0]        rd_word,
    output mem_pkg::mem_rsp_t       a_rsp,
    output logic                    a_rsp_valid,
    input  wire logic               a_rsp_ready,
    output mem_pkg::mem_rsp_t       b_rsp,
    output logic                    b_rsp_valid,
    input  wire logic               b_rsp_ready,
    output logic                    slot_free
);

    mem_pkg::mem_rsp_t  rsp_in;
    logic [31:0]        shifted;
    logic [31:0]        load_val;

    mem_pkg::mem_rsp_t  buf_rsp [0:1];
    logic               buf_port [0:1];
    logic               wr_ptr;
    logic               rd_ptr;
    logic [1:0]         count;
    logic               head_valid;
    logic               pop;

    // ----------------------------------------------------------------------
    // Extract and extend
    // ----------------------------------------------------------------------
    assign shifted = rd_word >> {rd_op.addr[1:0], 3'b000};

    always_comb begin
        case (rd_op.size)
            mem_pkg::size_byte: begin
                load_val = rd_op.uns ? {24'd0, shifted[7:0]}
                                     : {{24{shifted[7]}}, shifted[7:0]};
            end
            mem_pkg::size_half: begin
                load_val = rd_op.uns ? {16'd0, shifted[15:0]}
                                     : {{16{shifted[15]}}, shifted[15:0]};
            end
            default: begin
                load_val = shifted;         // Word, offset is zero
            end
        endcase
    end

    always_comb begin
        rsp_in.err  = !rd_op.ok;
        rsp_in.wr   = rd_op.wr;
        rsp_in.data = (rd_op.wr || !rd_op.ok) ? 32'd0 : load_val;
    end

    // ----------------------------------------------------------------------
    // In-order response buffer
    // ----------------------------------------------------------------------
    assign head_valid  = (count != 2'd0);
    assign a_rsp_valid = head_valid && !buf_port[rd_ptr];
    assign b_rsp_valid = head_valid && buf_port[rd_ptr];
    assign a_rsp       = buf_rsp[rd_ptr];
    assign b_rsp       = buf_rsp[rd_ptr];

    assign pop       = (a_rsp_valid && a_rsp_ready) || (b_rsp_valid && b_rsp_ready);
    assign slot_free = pop;                 // Returns a credit to the arbiter

    always_ff @(posedge CLK) begin
        if (rd_valid) begin
            buf_rsp[wr_ptr]  <= rsp_in;
            buf_port[wr_ptr] <= rd_op.port_id;
        end
    end

    // Credits keep the push from ever hitting a full buffer
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (rd_valid) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            case ({rd_valid, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys (
    input  wire logic               CLK,
    input  wire logic               rst_n,
    // Port A, load/store unit
    input  wire mem_pkg::mem_cmd_t  a_cmd,
    input  wire logic               a_cmd_valid,
    output logic                    a_cmd_ready,
    output mem_pkg::mem_rsp_t       a_rsp,
    output logic                    a_rsp_valid,
    input  wire logic               a_rsp_ready,
    // Port B, host or DMA
    input  wire mem_pkg::mem_cmd_t  b_cmd,
    input  wire logic               b_cmd_valid,
    output logic                    b_cmd_ready,
    output mem_pkg::mem_rsp_t       b_rsp,
    output logic                    b_rsp_valid,
    input  wire logic               b_rsp_ready
);

    mem_pkg::ram_op_t   ram_op;
    logic               op_valid;
    mem_pkg::ram_op_t   rd_op;
    logic               rd_valid;
    logic [31:0]        rd_word;
    logic               slot_free;

    // ----------------------------------------------------------------------
    // Request, memory, response
    // ----------------------------------------------------------------------
    mem_req_arbiter arb0 (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .a_cmd       (a_cmd),
        .a_cmd_valid (a_cmd_valid),
        .a_cmd_ready (a_cmd_ready),
        .b_cmd       (b_cmd),
        .b_cmd_valid (b_cmd_valid),
        .b_cmd_ready (b_cmd_ready),
        .slot_free   (slot_free),
        .ram_op      (ram_op),
        .op_valid    (op_valid)
    );

    data_ram ram0 (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .ram_op   (ram_op),
        .op_valid (op_valid),
        .rd_op    (rd_op),
        .rd_valid (rd_valid),
        .rd_word  (rd_word)
    );

    load_align align0 (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .rd_op       (rd_op),
        .rd_valid    (rd_valid),
        .rd_word     (rd_word),
        .a_rsp       (a_rsp),
        .a_rsp_valid (a_rsp_valid),
        .a_rsp_ready (a_rsp_ready),
        .b_rsp       (b_rsp),
        .b_rsp_valid (b_rsp_valid),
        .b_rsp_ready (b_rsp_ready),
        .slot_free   (slot_free)
    );

endmodule

`default_nettype wire

/* mem_subsys_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module mem_subsys_tb;

    localparam int NUM_TESTS  = 6;
    localparam int AW         = `MEM_ADDR_W;
    localparam int FILL_WORDS = 16;
    localparam int MAX_WAIT   = 200;            // Cycles allowed for one handshake

    logic               CLK;
    logic               rst_n;
    mem_pkg::mem_cmd_t  a_cmd;
    logic               a_cmd_valid;
    logic               a_cmd_ready;
    mem_pkg::mem_rsp_t  a_rsp;
    logic               a_rsp_valid;
    logic               a_rsp_ready;
    mem_pkg::mem_cmd_t  b_cmd;
    logic               b_cmd_valid;
    logic               b_cmd_ready;
    mem_pkg::mem_rsp_t  b_rsp;
    logic               b_rsp_valid;
    logic               b_rsp_ready;

    logic [7:0]         model_mem [0:4*`MEM_WORDS-1];   // Byte image of the RAM
    mem_pkg::mem_rsp_t  exp_q [$];
    logic               port_q [$];                     // Port of each request in flight
    logic [31:0]        lcg_state = 32'hc0c8_0925;
    logic [31:0]        ready_rnd;
    int                 rsp_mode = 0;                   // 0 ready, 1 held low, 2 random
    int                 error_count = 0;
    int                 check_count = 0;

    mem_subsys dut0 (.*);

    always #2 CLK = ~CLK;

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic mem_pkg::mem_cmd_t build_cmd(input logic wr,
            input mem_pkg::access_size_e size, input logic uns,
            input logic [AW-1:0] addr, input logic [31:0] wdata);
        mem_pkg::mem_cmd_t c;
        c.wr    = wr;
        c.size  = size;
        c.uns   = uns;
        c.addr  = addr;
        c.wdata = wdata;
        return c;
    endfunction

    function automatic logic is_misaligned(input mem_pkg::mem_cmd_t c);
        return (c.size == mem_pkg::size_half && c.addr[0]) ||
               (c.size == mem_pkg::size_word && c.addr[1:0] != 2'b00);
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
            input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    // Little-endian byte lanes with the low store bytes at the addressed byte
    task automatic model_access(input mem_pkg::mem_cmd_t c, output mem_pkg::mem_rsp_t r);
        int          n;
        logic [31:0] w;
        logic [AW-1:0] ba;
        n = (c.size == mem_pkg::size_byte) ? 1 : (c.size == mem_pkg::size_half) ? 2 : 4;
        w = 32'd0;
        r.err  = is_misaligned(c);
        r.wr   = c.wr;
        r.data = 32'd0;
        if (!r.err) begin
            for (int i = 0; i < n; i++) begin
                ba = c.addr + AW'(i);
                if (c.wr)
                    model_mem[ba] = c.wdata[8*i +: 8];
                else
                    w[8*i +: 8] = model_mem[ba];
            end
            if (!c.wr && n == 1)
                r.data = c.uns ? w : {{24{w[7]}}, w[7:0]};
            else if (!c.wr && n == 2)
                r.data = c.uns ? w : {{16{w[15]}}, w[15:0]};
            else if (!c.wr)
                r.data = w;
        end
    endtask

    task automatic accept_cmd(input logic port, input mem_pkg::mem_cmd_t c);
        mem_pkg::mem_rsp_t r;
        model_access(c, r);
        exp_q.push_back(r);
        port_q.push_back(port);
    endtask

    task automatic take_rsp(input logic port, input mem_pkg::mem_rsp_t r);
        logic              exp_port;
        mem_pkg::mem_rsp_t exp_rsp;
        if (exp_q.size() == 0) begin
            report_error("a response arrived with no request outstanding");
        end else begin
            exp_port = port_q.pop_front();
            exp_rsp  = exp_q.pop_front();
            check_value("response port", 64'(port), 64'(exp_port));
            check_value(port ? "b_rsp" : "a_rsp", 64'(r), 64'(exp_rsp));
        end
    endtask

    // Handshakes are sampled mid-cycle, where inputs and outputs are settled
    always @(negedge CLK) begin
        if (rst_n) begin
            if (b_cmd_valid && a_cmd_ready)
                report_error("port A was ready while port B held a request");
            if (b_cmd_valid && b_cmd_ready)
                accept_cmd(1'b1, b_cmd);
            else if (a_cmd_valid && a_cmd_ready)
                accept_cmd(1'b0, a_cmd);
            if (a_rsp_valid && b_rsp_valid)
                report_error("responses were valid on both ports at once");
            if (a_rsp_valid && a_rsp_ready)
                take_rsp(1'b0, a_rsp);
            if (b_rsp_valid && b_rsp_ready)
                take_rsp(1'b1, b_rsp);
        end
    end

    always @(posedge CLK) begin
        #1;
        ready_rnd   = lcg_next();
        a_rsp_ready = (rsp_mode == 0) || (rsp_mode == 2 && ready_rnd[31]);
        b_rsp_ready = (rsp_mode == 0) || (rsp_mode == 2 && ready_rnd[30]);
    end

    // Called 1 ns after a rising edge and returns 1 ns after the transfer edge
    task automatic issue(input logic port, input mem_pkg::mem_cmd_t c);
        int waited;
        waited = 0;
        if (port) begin
            b_cmd       = c;
            b_cmd_valid = 1'b1;
        end else begin
            a_cmd       = c;
            a_cmd_valid = 1'b1;
        end
        @(negedge CLK);
        while (!(port ? b_cmd_ready : a_cmd_ready) && waited < MAX_WAIT) begin
            waited++;
            @(negedge CLK);
        end
        if (waited == MAX_WAIT)
            report_error("a request was never accepted");
        @(posedge CLK);
        #1;
        if (port)
            b_cmd_valid = 1'b0;
        else
            a_cmd_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (port_q.size() != 0 && waited < MAX_WAIT) begin
            waited++;
            @(negedge CLK);
        end
        if (port_q.size() != 0)
            report_error("responses were still missing after the wait limit");
        @(posedge CLK);
        #1;
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic fill_memory();
        logic [AW-1:0] addr;
        for (int i = 0; i < FILL_WORDS; i++) begin
            addr = AW'(4 * i);
            issue(1'b0, build_cmd(1'b1, mem_pkg::size_word, 1'b0, addr,
                                  (32'(addr) * 32'h9e37_79b9) ^ 32'ha5c3_0f81));
        end
        drain();
    endtask

    task automatic word_store_load();
        issue(1'b0, build_cmd(1'b1, mem_pkg::size_word, 1'b0, AW'(4), lcg_next()));
        issue(1'b0, build_cmd(1'b0, mem_pkg::size_word, 1'b0, AW'(4), 32'd0));
        drain();
    endtask

    task automatic sub_word_merge();
        logic [31:0] vals;
        vals = 32'h24c3_7f81;                   // Both signs in the byte lanes
        for (int i = 0; i < 4; i++) begin
            issue(1'b0, build_cmd(1'b1, mem_pkg::size_byte, 1'b0, AW'(8 + i),
                                  {24'hffffee, vals[8*i +: 8]}));
            issue(1'b0, build_cmd(1'b0, mem_pkg::size_word, 1'b0, AW'(8), 32'd0));
        end
        for (int i = 0; i < 8; i++)
            issue(1'b0, build_cmd(1'b0, mem_pkg::size_byte, i[0], AW'(8 + i / 2), 32'd0));
        issue(1'b0, build_cmd(1'b1, mem_pkg::size_half, 1'b0, AW'(8), 32'hbeef_5e01));
        issue(1'b0, build_cmd(1'b0, mem_pkg::size_word, 1'b0, AW'(8), 32'd0));
        issue(1'b0, build_cmd(1'b1, mem_pkg::size_half, 1'b0, AW'(10), 32'hdead_9abc));
        issue(1'b0, build_cmd(1'b0, mem_pkg::size_word, 1'b0, AW'(8), 32'd0));
        for (int i = 0; i < 4; i++)
            issue(1'b0, build_cmd(1'b0, mem_pkg::size_half, i[0], AW'(8 + 2 * (i / 2)), 32'd0));
        drain();
    endtask

    task automatic forwarding_hazards();
        issue(1'b0, build_cmd(1'b1, mem_pkg::size_word, 1'b0, AW'(12), lcg_next()));
        issue(1'b0, build_cmd(1'b0, mem_pkg::size_word, 1'b0, AW'(12), 32'd0));
        drain();
        issue(1'b0, build_cmd(1'b1, mem_pkg::size_byte, 1'b0, AW'(13), lcg_next()));
        @(posedge CLK);
        #1;
        issue(1'b0, build_cmd(1'b0, mem_pkg::size_word, 1'b0, AW'(12), 32'd0));
        drain();
        issue(1'b1, build_cmd(1'b1, mem_pkg::size_half, 1'b0, AW'(14), lcg_next()));
        issue(1'b0, build_cmd(1'b0, mem_pkg::size_byte, 1'b0, AW'(15), 32'd0));
        drain();
    endtask

    task automatic misaligned_access();
        issue(1'b0, build_cmd(1'b1, mem_pkg::size_half, 1'b0, AW'(21), 32'hffff_ffff));
        issue(1'b1, build_cmd(1'b1, mem_pkg::size_word, 1'b0, AW'(22), 32'h0bad_0bad));
        issue(1'b0, build_cmd(1'b0, mem_pkg::size_word, 1'b1, AW'(23), 32'd0));
        issue(1'b1, build_cmd(1'b0, mem_pkg::size_half, 1'b0, AW'(23), 32'd0));
        issue(1'b0, build_cmd(1'b0, mem_pkg::size_word, 1'b0, AW'(20), 32'd0));
        drain();
    endtask

    task automatic port_priority();
        fork
            issue(1'b0, build_cmd(1'b0, mem_pkg::size_word, 1'b0, AW'(24), 32'd0));
            issue(1'b1, build_cmd(1'b1, mem_pkg::size_word, 1'b0, AW'(24), lcg_next()));
            begin
                @(negedge CLK);
                check_value("a_cmd_ready", 64'(a_cmd_ready), 64'd0);
                check_value("b_cmd_ready", 64'(b_cmd_ready), 64'd1);
            end
        join
        drain();
        fork
            issue(1'b0, build_cmd(1'b1, mem_pkg::size_word, 1'b0, AW'(28), lcg_next()));
            issue(1'b1, build_cmd(1'b0, mem_pkg::size_word, 1'b0, AW'(28), 32'd0));
        join
        drain();
    endtask

    task automatic random_traffic(input logic port, input int count);
        logic [31:0]           r;
        mem_pkg::access_size_e size;
        logic [1:0]            off;
        for (int i = 0; i < count; i++) begin
            r = lcg_next();
            case (r[31:30])
                2'd0:    size = mem_pkg::size_byte;
                2'd1:    size = mem_pkg::size_half;
                default: size = mem_pkg::size_word;
            endcase
            off = r[23:22];
            if (r[21:19] != 3'd0 && size == mem_pkg::size_half)   // Mostly aligned
                off[0] = 1'b0;
            else if (r[21:19] != 3'd0 && size == mem_pkg::size_word)
                off = 2'b00;
            issue(port, build_cmd(r[18], size, r[17], AW'({r[27:24], off}), lcg_next()));
            if (r[16]) begin
                @(posedge CLK);
                #1;
            end
        end
    endtask

    task automatic backpressure_traffic();
        rsp_mode = 1;
        issue(1'b0, build_cmd(1'b0, mem_pkg::size_word, 1'b0, AW'(0), 32'd0));
        issue(1'b1, build_cmd(1'b0, mem_pkg::size_half, 1'b1, AW'(2), 32'd0));
        fork
            issue(1'b0, build_cmd(1'b1, mem_pkg::size_byte, 1'b0, AW'(1), lcg_next()));
            begin
                repeat (4) begin
                    @(negedge CLK);
                    check_value("a_cmd_ready", 64'(a_cmd_ready), 64'd0);
                    check_value("b_cmd_ready", 64'(b_cmd_ready), 64'd0);
                end
                check_value("requests in flight", 64'(port_q.size()), 64'd2);
                rsp_mode = 0;
            end
        join
        drain();
        rsp_mode = 2;
        fork
            random_traffic(1'b0, 8);
            random_traffic(1'b1, 8);
        join
        rsp_mode = 0;
        drain();
    endtask

    // ----------------------------------------------------------------------
    // Sequence and watchdog
    // ----------------------------------------------------------------------
    initial begin
        CLK         = 1'b0;
        rst_n       = 1'b0;
        a_cmd       = '0;
        a_cmd_valid = 1'b0;
        a_rsp_ready = 1'b1;
        b_cmd       = '0;
        b_cmd_valid = 1'b0;
        b_rsp_ready = 1'b1;
        repeat (3) @(posedge CLK);
        #1;
        rst_n = 1'b1;
        fill_memory();
        word_store_load();
        sub_word_merge();
        forwarding_hazards();
        misaligned_access();
        port_priority();
        backpressure_traffic();
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        #(NUM_TESTS * 200);
        report_error("the watchdog timer expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
mem_pkg.sv
mem_req_arbiter.sv
data_ram.sv
load_align.sv
mem_subsys.sv
mem_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the data-memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module mem_subsys_tb -f src.f

out=$(./obj_dir/Vmem_subsys_tb)
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
